// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - regfile.sv
      - if_stage.sv
      - id_stage.sv
      - exe_wb_stage.sv
      - cpu_ctrl_regs.sv
      - cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_cpu_top.sv

// ==== cpu_ctrl_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module cpu_ctrl_regs import cpu_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    // APB slave
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [3:0] paddr,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    // Core status
    input  logic       retire,
    input  logic       id_valid,
    output cpu_ctrl_t  ctrl
);

    cpu_ctrl_t ctrl_q;
    word_t     retired_cnt;
    word_t     status_word;
    logic      apb_wr;

    // No wait states
    assign pready = 1'b1;

    // Write commits in the access phase
    assign apb_wr = psel & penable & pwrite;

    //////////////////////////////////////////////////
    // Control register and retire counter
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ctrl_q      <= '0;
            retired_cnt <= '0;
        end else begin
            if (apb_wr && (paddr == `CTRL_REG_OFS)) begin
                ctrl_q.run <= pwdata[0];
            end
            // RETIRED ignores writes
            if (retire) begin
                retired_cnt <= retired_cnt + 32'd1;
            end
        end
    end

    // Run in bit 0, decode valid in bit 1
    assign status_word = {30'b0, id_valid, ctrl_q.run};

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////
    always_comb begin
        case (paddr)
            `CTRL_REG_OFS:    prdata = ctrl_q;
            `STATUS_REG_OFS:  prdata = status_word;
            `RETIRED_REG_OFS: prdata = retired_cnt;
            default:          prdata = '0;
        endcase
    end

    assign ctrl = ctrl_q;

endmodule

`default_nettype wire

// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

//////////////////////////////////////////////////
// Fetch start
//////////////////////////////////////////////////
// One word before the boot address, first seq_pc lands on 0x1C000000
`define CPU_RESET_PC    32'h1BFF_FFFC

//////////////////////////////////////////////////
// Opcode fields of the supported subset
//////////////////////////////////////////////////
// inst[31:15]
`define OP_ADD_W        17'h00020
`define OP_SUB_W        17'h00022
// inst[31:22]
`define OP_ADDI_W       10'h00a
// inst[31:25]
`define OP_LU12I_W      7'h0a
// inst[31:26]
`define OP_BEQ          6'h16
`define OP_BNE          6'h17
`define OP_B            6'h14

// APB register map
`define CTRL_REG_OFS    4'h0
`define STATUS_REG_OFS  4'h4
`define RETIRED_REG_OFS 4'h8

`endif

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    //////////////////////////////////////////////////
    // Basic widths
    //////////////////////////////////////////////////
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_num_t;

    // Opcode slices, one per instruction format
    typedef logic [16:0] op17_t;
    typedef logic [9:0]  op10_t;
    typedef logic [6:0]  op7_t;
    typedef logic [5:0]  op6_t;

    // ALU function picked in decode
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_LUI,
        ALU_NONE
    } alu_op_t;

    //////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////
    typedef struct packed {
        word_t inst;
        word_t pc;
    } if_to_id_t;

    typedef struct packed {
        word_t    pc;
        alu_op_t  alu_op;
        word_t    src_a;
        word_t    src_b;
        reg_num_t dest;
        logic     wen;
    } id_to_exe_t;

    // Debug writeback trace
    typedef struct packed {
        word_t    pc;
        logic     we;
        reg_num_t wnum;
        word_t    wdata;
    } wb_trace_t;

    // CTRL register, run in bit 0
    typedef struct packed {
        logic [30:0] rsvd;
        logic        run;
    } cpu_ctrl_t;

endpackage

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    // Instruction SRAM
    output logic       inst_sram_en,
    output word_t      inst_sram_addr,
    input  word_t      inst_sram_rdata,
    // APB
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [3:0] paddr,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    // Debug writeback trace
    output wb_trace_t  debug_wb
);

    //////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////
    logic       if_to_id_valid;
    if_to_id_t  if_to_id;
    logic       id_allowin;
    logic       br_taken;
    word_t      br_target;
    logic       id_to_exe_valid;
    id_to_exe_t id_to_exe;
    logic       exe_dest_valid;
    reg_num_t   exe_dest;
    // Register file
    reg_num_t   rf_raddr1, rf_raddr2;
    word_t      rf_rdata1, rf_rdata2;
    logic       rf_we;
    reg_num_t   rf_waddr;
    word_t      rf_wdata;
    // Control
    logic       retire;
    cpu_ctrl_t  ctrl;

    if_stage u_if (
        .clk, .resetn, .run(ctrl.run),
        .inst_sram_en, .inst_sram_addr, .inst_sram_rdata,
        .id_allowin, .br_taken, .br_target,
        .if_to_id_valid, .if_to_id
    );

    id_stage u_id (
        .clk, .resetn, .if_to_id_valid, .if_to_id,
        .id_allowin, .br_taken, .br_target,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .exe_dest_valid, .exe_dest, .id_to_exe_valid, .id_to_exe
    );

    exe_wb_stage u_exe_wb (
        .clk, .resetn, .id_to_exe_valid, .id_to_exe,
        .exe_dest_valid, .exe_dest, .rf_we, .rf_waddr, .rf_wdata,
        .retire, .wb_trace(debug_wb)
    );

    regfile u_rf (
        .clk, .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rf_rdata1),
        .rdata2(rf_rdata2), .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    // Decode holds an entry when it issues or when it is stalled
    cpu_ctrl_regs u_ctrl (
        .clk, .resetn, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .retire, .id_valid(id_to_exe_valid | ~id_allowin), .ctrl
    );

endmodule

`default_nettype wire

// ==== exe_wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module exe_wb_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    // From decode
    input  logic       id_to_exe_valid,
    input  id_to_exe_t id_to_exe,
    // Back to decode for the hazard check
    output logic       exe_dest_valid,
    output reg_num_t   exe_dest,
    // Register file write
    output logic       rf_we,
    output reg_num_t   rf_waddr,
    output word_t      rf_wdata,
    // Retire and trace
    output logic       retire,
    output wb_trace_t  wb_trace
);

    logic       exe_valid;
    id_to_exe_t exe_q;
    word_t      alu_result;

    //////////////////////////////////////////////////
    // Stage register, always accepts
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= id_to_exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_exe_valid) begin
            exe_q <= id_to_exe;
        end
    end

    // ALU
    always_comb begin
        case (exe_q.alu_op)
            ALU_ADD: alu_result = exe_q.src_a + exe_q.src_b;
            ALU_SUB: alu_result = exe_q.src_a - exe_q.src_b;
            ALU_LUI: alu_result = exe_q.src_b;
            default: alu_result = '0;
        endcase
    end

    // Write lands at the end of this cycle
    assign rf_we    = exe_valid & exe_q.wen;
    assign rf_waddr = exe_q.dest;
    assign rf_wdata = alu_result;

    assign exe_dest_valid = rf_we;
    assign exe_dest       = exe_q.dest;

    // Branches and no-ops retire with we low
    assign retire   = exe_valid;
    assign wb_trace = '{pc: exe_q.pc, we: rf_we, wnum: exe_q.dest, wdata: alu_result};

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
cpu_pkg.sv
regfile.sv
if_stage.sv
id_stage.sv
exe_wb_stage.sv
cpu_ctrl_regs.sv
cpu_top.sv
tb_clk_gen.sv
tb_cpu_top.sv

// ==== id_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module id_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    // From fetch
    input  logic       if_to_id_valid,
    input  if_to_id_t  if_to_id,
    output logic       id_allowin,
    output logic       br_taken,
    output word_t      br_target,
    // Register file reads
    output reg_num_t   rf_raddr1,
    output reg_num_t   rf_raddr2,
    input  word_t      rf_rdata1,
    input  word_t      rf_rdata2,
    // Hazard source from execute
    input  logic       exe_dest_valid,
    input  reg_num_t   exe_dest,
    // To execute
    output logic       id_to_exe_valid,
    output id_to_exe_t id_to_exe
);

    logic      id_valid;
    if_to_id_t id_q;
    word_t     inst;
    reg_num_t  rd;
    reg_num_t  rj;
    reg_num_t  rk;
    op17_t     op_31_15;
    op10_t     op_31_22;
    op7_t      op_31_25;
    op6_t      op_31_26;
    logic      inst_add, inst_sub, inst_addi, inst_lu12i;
    logic      inst_beq, inst_bne, inst_b;
    logic      use_r1, use_r2;
    logic      hazard;
    logic      rs_equal;
    word_t     si12_ext;
    word_t     lui_imm;
    word_t     offs16_ext;
    word_t     offs26_ext;
    alu_op_t   alu_op;

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            // Sequential fetch behind a taken branch is cancelled
            id_valid <= if_to_id_valid & ~br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin
            id_q <= if_to_id;
        end
    end

    // Field extraction
    assign inst     = id_q.inst;
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign op_31_15 = inst[31:15];
    assign op_31_22 = inst[31:22];
    assign op_31_25 = inst[31:25];
    assign op_31_26 = inst[31:26];

    assign inst_add   = (op_31_15 == `OP_ADD_W);
    assign inst_sub   = (op_31_15 == `OP_SUB_W);
    assign inst_addi  = (op_31_22 == `OP_ADDI_W);
    assign inst_lu12i = (op_31_25 == `OP_LU12I_W);
    assign inst_beq   = (op_31_26 == `OP_BEQ);
    assign inst_bne   = (op_31_26 == `OP_BNE);
    assign inst_b     = (op_31_26 == `OP_B);

    // Branches compare rj against rd
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (inst_beq | inst_bne) ? rd : rk;

    //////////////////////////////////////////////////
    // RAW hazard, no forwarding
    //////////////////////////////////////////////////
    assign use_r1 = inst_add | inst_sub | inst_addi | inst_beq | inst_bne;
    assign use_r2 = inst_add | inst_sub | inst_beq | inst_bne;
    assign hazard = id_valid & exe_dest_valid &
                    ((use_r1 & (rf_raddr1 != '0) & (rf_raddr1 == exe_dest)) |
                     (use_r2 & (rf_raddr2 != '0) & (rf_raddr2 == exe_dest)));

    assign id_allowin      = ~id_valid | ~hazard;
    assign id_to_exe_valid = id_valid & ~hazard;

    // Immediates
    assign si12_ext   = {{20{inst[21]}}, inst[21:10]};
    assign lui_imm    = {inst[24:5], 12'b0};
    assign offs16_ext = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26_ext = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        if (inst_add || inst_addi) begin
            alu_op = ALU_ADD;
        end else if (inst_sub) begin
            alu_op = ALU_SUB;
        end else if (inst_lu12i) begin
            alu_op = ALU_LUI;
        end else begin
            // Branches and unknown encodings
            alu_op = ALU_NONE;
        end
    end

    //////////////////////////////////////////////////
    // Branch resolution
    //////////////////////////////////////////////////
    assign rs_equal  = (rf_rdata1 == rf_rdata2);
    // Held back while stalled, operands may be stale
    assign br_taken  = id_valid & ~hazard &
                       ((inst_beq & rs_equal) | (inst_bne & ~rs_equal) | inst_b);
    assign br_target = id_q.pc + (inst_b ? offs26_ext : offs16_ext);

    assign id_to_exe = '{
        pc:     id_q.pc,
        alu_op: alu_op,
        src_a:  rf_rdata1,
        src_b:  inst_addi ? si12_ext : (inst_lu12i ? lui_imm : rf_rdata2),
        dest:   rd,
        wen:    (alu_op != ALU_NONE) && (rd != '0)
    };

endmodule

`default_nettype wire

// ==== if_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module if_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      run,
    // Instruction SRAM
    output logic      inst_sram_en,
    output word_t     inst_sram_addr,
    input  word_t     inst_sram_rdata,
    // From decode
    input  logic      id_allowin,
    input  logic      br_taken,
    input  word_t     br_target,
    // To decode
    output logic      if_to_id_valid,
    output if_to_id_t if_to_id
);

    logic  if_valid;
    word_t if_pc;
    word_t seq_pc;
    word_t next_pc;
    logic  if_allowin;
    logic  fetch;
    // SRAM output belongs to the held entry only right after a read
    logic  rdata_live;
    word_t inst_hold;
    word_t if_inst;

    //////////////////////////////////////////////////
    // Handshake and request
    //////////////////////////////////////////////////
    assign if_allowin     = ~if_valid | id_allowin;
    // Run bit gates new requests, stall freezes them
    assign fetch          = if_allowin & run;
    assign seq_pc         = if_pc + 32'd4;
    assign next_pc        = br_taken ? br_target : seq_pc;
    assign inst_sram_en   = fetch;
    assign inst_sram_addr = next_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid   <= 1'b0;
            if_pc      <= `CPU_RESET_PC;
            rdata_live <= 1'b0;
        end else begin
            rdata_live <= fetch;
            // Wrong-path entry is overwritten by the target fetch
            if (if_allowin) begin
                if_valid <= fetch;
            end
            if (fetch) begin
                if_pc <= next_pc;
            end else if (br_taken) begin
                // Parked so that seq_pc is the target on resume
                if_pc <= br_target - 32'd4;
            end
        end
    end

    // Keep the word while decode is stalled
    always_ff @(posedge clk) begin
        if (rdata_live) begin
            inst_hold <= inst_sram_rdata;
        end
    end

    assign if_inst        = rdata_live ? inst_sram_rdata : inst_hold;
    assign if_to_id_valid = if_valid;
    assign if_to_id       = '{inst: if_inst, pc: if_pc};

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regfile import cpu_pkg::*; (
    input  logic     clk,
    // Read ports
    input  reg_num_t raddr1,
    input  reg_num_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    // Write port
    input  logic     we,
    input  reg_num_t waddr,
    input  word_t    wdata
);

    word_t rf [32];

    always_ff @(posedge clk) begin
        // r0 is never stored
        if (we && (waddr != '0)) begin
            rf[waddr] <= wdata;
        end
    end

    // Asynchronous reads, no bypass of the same-cycle write
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

// Free-running testbench clock
module tb_clk_gen #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half period per toggle
    always #(PERIOD / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// ==== tb_cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module tb_cpu_top import cpu_pkg::*; ();

    // Program shape
    localparam int    PROLOGUE = 7;
    localparam int    BLOCK    = 16;
    localparam int    NBLOCKS  = 3;
    localparam int    PROG_LEN = PROLOGUE + BLOCK * NBLOCKS + 1;
    localparam word_t BOOT_PC  = 32'h1C00_0000;
    // Instruction kinds of the skeleton
    localparam int K_ADD = 0, K_SUB = 1, K_ADDI = 2, K_LUI = 3;
    localparam int K_BEQ = 4, K_BNE = 5, K_B = 6, K_NOP = 7;

    logic       clk;
    logic       resetn;
    logic       inst_sram_en;
    word_t      inst_sram_addr;
    word_t      inst_sram_rdata = '0;
    logic       psel, penable, pwrite;
    logic [3:0] paddr;
    word_t      pwdata, prdata;
    logic       pready;
    wb_trace_t  debug_wb;

    int         errors = 0;
    int         checks = 0;
    int         trace_count = 0;
    logic       run_seen = 1'b0;
    wb_trace_t  exp_q[$];
    word_t      end_pc;
    logic [15:0] lfsr_state = 16'd545;
    // SRAM request seen in the previous cycle
    logic       req_en = 1'b0;
    word_t      req_addr = '0;

    // Skeleton of one block, bit i of the masks belongs to entry i
    int skel_kind [BLOCK] = '{K_LUI, K_ADDI, K_ADD, K_SUB, K_BEQ, K_ADDI, K_ADD, K_BNE,
                              K_ADDI, K_BNE, K_B, K_NOP, K_SUB, K_BEQ, K_ADD, K_ADD};
    // rj taken from the previous rd
    bit [15:0] skel_dep  = 16'b1001_0000_0100_1110;
    // rj equal to rd, so beq always taken and bne never
    bit [15:0] skel_same = 16'b0000_0010_0001_0000;

    // Decoded program, one entry per word
    int       f_kind [PROG_LEN];
    reg_num_t f_rd   [PROG_LEN];
    reg_num_t f_rj   [PROG_LEN];
    reg_num_t f_rk   [PROG_LEN];
    logic [19:0] f_imm [PROG_LEN];
    int       f_off  [PROG_LEN];
    word_t    prog_mem [PROG_LEN];

    tb_clk_gen #(.PERIOD(8.0)) u_clk (.clk);

    cpu_top uut (
        .clk, .resetn, .inst_sram_en, .inst_sram_addr, .inst_sram_rdata,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .debug_wb
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        checks++;
        assert (got === exp)
            else report_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        int j;
        v = '0;
        for (j = 0; j < n; j++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // LoongArch32 encodings of the subset
    function automatic word_t encode(input int i);
        logic [15:0] o16;
        logic [25:0] o26;
        o16 = f_off[i];
        o26 = f_off[i];
        case (f_kind[i])
            K_ADD:   return {17'h00020, f_rk[i], f_rj[i], f_rd[i]};
            K_SUB:   return {17'h00022, f_rk[i], f_rj[i], f_rd[i]};
            K_ADDI:  return {10'h00a, f_imm[i][11:0], f_rj[i], f_rd[i]};
            K_LUI:   return {7'h0a, f_imm[i], f_rd[i]};
            K_BEQ:   return {6'h16, o16, f_rj[i], f_rd[i]};
            K_BNE:   return {6'h17, o16, f_rj[i], f_rd[i]};
            K_B:     return {6'h14, o26[15:0], o26[25:16]};
            default: return 32'h0000_0000;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Program build and ISA model
    //////////////////////////////////////////////////
    task automatic build_program();
        int i, k, b;
        reg_num_t prev_rd;
        logic [31:0] r;
        // Prologue gives r1..r7 known values
        for (i = 0; i < PROLOGUE; i++) begin
            draw_bits(12, r);
            f_kind[i] = K_ADDI;
            f_rd[i]   = reg_num_t'(i + 1);
            f_rj[i]   = '0;
            f_rk[i]   = '0;
            f_imm[i]  = {8'h0, r[11:0]};
            f_off[i]  = 0;
        end
        prev_rd = reg_num_t'(PROLOGUE);
        for (b = 0; b < NBLOCKS; b++) begin
            for (k = 0; k < BLOCK; k++) begin
                i = PROLOGUE + b * BLOCK + k;
                f_kind[i] = skel_kind[k];
                draw_bits(3, r);
                f_rd[i] = {2'b00, r[2:0]};
                draw_bits(3, r);
                f_rj[i] = skel_dep[k] ? prev_rd : {2'b00, r[2:0]};
                draw_bits(3, r);
                f_rk[i] = {2'b00, r[2:0]};
                draw_bits(20, r);
                f_imm[i] = r[19:0];
                // Forward skip of one or two words
                draw_bits(1, r);
                f_off[i] = 2 + r[0];
                if (skel_same[k]) begin
                    f_rj[i] = f_rd[i];
                end
                prev_rd = f_rd[i];
            end
        end
        // Terminal self-loop
        f_kind[PROG_LEN-1] = K_B;
        f_off[PROG_LEN-1]  = 0;
        for (i = 0; i < PROG_LEN; i++) begin
            prog_mem[i] = encode(i);
        end
    endtask

    // Walks the program up to the self-loop, one expected entry per retire
    task automatic run_model();
        word_t gpr [32];
        int i;
        logic done, taken, alu;
        word_t val;
        wb_trace_t e;
        for (i = 0; i < 32; i++) begin
            gpr[i] = '0;
        end
        i = 0;
        done = 1'b0;
        while (!done) begin
            taken = 1'b0;
            alu   = 1'b1;
            val   = '0;
            case (f_kind[i])
                K_ADD:  val = gpr[f_rj[i]] + gpr[f_rk[i]];
                K_SUB:  val = gpr[f_rj[i]] - gpr[f_rk[i]];
                K_ADDI: val = gpr[f_rj[i]] + {{20{f_imm[i][11]}}, f_imm[i][11:0]};
                K_LUI:  val = {f_imm[i], 12'h000};
                default: begin
                    alu   = 1'b0;
                    taken = (f_kind[i] == K_B) ||
                            ((f_kind[i] == K_BEQ) && (gpr[f_rj[i]] == gpr[f_rd[i]])) ||
                            ((f_kind[i] == K_BNE) && (gpr[f_rj[i]] != gpr[f_rd[i]]));
                end
            endcase
            e = '{pc: BOOT_PC + 32'(4 * i), we: alu && (f_rd[i] != 0), wnum: f_rd[i],
                  wdata: val};
            // r0 stays zero
            if (e.we) begin
                gpr[f_rd[i]] = val;
            end
            exp_q.push_back(e);
            if (i == PROG_LEN - 1) begin
                done = 1'b1;
            end else begin
                i = taken ? i + f_off[i] : i + 1;
            end
        end
        end_pc = BOOT_PC + 32'(4 * (PROG_LEN - 1));
    endtask

    //////////////////////////////////////////////////
    // Instruction SRAM, answer one cycle late
    //////////////////////////////////////////////////
    function automatic word_t sram_word(input word_t addr);
        word_t idx;
        idx = (addr - BOOT_PC) >> 2;
        // Outside the program reads as a no-op
        if (addr[1:0] == 2'b00 && addr >= BOOT_PC && idx < PROG_LEN) begin
            return prog_mem[idx];
        end
        return 32'h0000_0000;
    endfunction

    always @(negedge clk) begin
        if (req_en) begin
            inst_sram_rdata <= sram_word(req_addr);
        end
        req_en   <= inst_sram_en;
        req_addr <= inst_sram_addr;
    end

    // APB, setup then access, no wait states expected
    task automatic apb_write(input logic [3:0] addr, input word_t data);
        @(negedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(negedge clk);
        penable <= 1'b1;
        @(negedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output word_t data);
        @(negedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(negedge clk);
        penable <= 1'b1;
        // Settled well before the completing edge
        #1;
        data = prdata;
        checks++;
        assert (pready === 1'b1) else report_error("pready low in access phase");
        @(negedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Checkers
    //////////////////////////////////////////////////
    // No fetch request before run
    assert property (@(posedge clk) disable iff (!resetn) !run_seen |-> !inst_sram_en)
        else report_error("instruction fetch requested before run was set");

    always @(negedge clk) begin : trace_monitor
        wb_trace_t exp_e;
        if (resetn && !run_seen) begin
            checks++;
            assert (uut.retire !== 1'b1 && debug_wb.we !== 1'b1)
                else report_error("trace activity before run was set");
        end
        if (resetn && uut.retire === 1'b1) begin
            trace_count++;
            // Past the model's end only the self-loop retires
            if (exp_q.size() == 0) begin
                exp_e = '{pc: end_pc, we: 1'b0, wnum: '0, wdata: '0};
            end else begin
                exp_e = exp_q.pop_front();
            end
            checks++;
            assert (debug_wb.pc === exp_e.pc && debug_wb.we === exp_e.we)
                else report_error($sformatf("retired pc %h we %b, expected pc %h we %b",
                                  debug_wb.pc, debug_wb.we, exp_e.pc, exp_e.we));
            if (exp_e.we) begin
                checks++;
                assert (debug_wb.wnum === exp_e.wnum && debug_wb.wdata === exp_e.wdata)
                    else report_error($sformatf("pc %h wrote r%0d=%h, expected r%0d=%h",
                                      exp_e.pc, debug_wb.wnum, debug_wb.wdata,
                                      exp_e.wnum, exp_e.wdata));
            end
        end
    end

    // Watchdog sized from the program length
    initial begin : watchdog
        repeat (PROG_LEN * 4 + 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", PROG_LEN * 4 + 200);
        $display("** FAIL **");
        $finish;
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin : main_seq
        word_t rdata;
        int held;
        int stop_at;
        resetn  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        build_program();
        run_model();
        stop_at = exp_q.size() / 2;

        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn <= 1'b1;

        // Idle after reset
        repeat (10) @(negedge clk);
        apb_read(`STATUS_REG_OFS, rdata);
        check_value("STATUS after reset", rdata, 32'h0);
        apb_read(`RETIRED_REG_OFS, rdata);
        check_value("RETIRED after reset", rdata, 32'h0);

        // Start and run about half the program
        run_seen = 1'b1;
        apb_write(`CTRL_REG_OFS, 32'h1);
        apb_read(`CTRL_REG_OFS, rdata);
        check_value("CTRL readback", rdata, 32'h1);
        apb_read(`STATUS_REG_OFS, rdata);
        check_value("STATUS run bit", {31'h0, rdata[0]}, 32'h1);
        while (trace_count < stop_at) @(negedge clk);

        // Stop, let the pipe drain, then expect silence
        apb_write(`CTRL_REG_OFS, 32'h0);
        repeat (10) @(negedge clk);
        held = trace_count;
        repeat (20) begin
            @(negedge clk);
            checks++;
            assert (inst_sram_en === 1'b0) else report_error("fetch while run was clear");
        end
        checks++;
        assert (trace_count == held) else report_error("trace entries while run was clear");
        apb_read(`STATUS_REG_OFS, rdata);
        check_value("STATUS when stopped", rdata, 32'h0);
        apb_read(`RETIRED_REG_OFS, rdata);
        check_value("RETIRED when stopped", rdata, 32'(trace_count));

        // Resume and finish the program
        apb_write(`CTRL_REG_OFS, 32'h1);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (10) @(negedge clk);
        apb_write(`CTRL_REG_OFS, 32'h0);
        repeat (10) @(negedge clk);
        apb_read(`RETIRED_REG_OFS, rdata);
        check_value("RETIRED at end", rdata, 32'(trace_count));

        $display("Checks: %0d, errors: %0d, retired: %0d", checks, errors, trace_count);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
